// File: bench/mem_sys_tb.sv
`timescale 1ns/1ps

module mem_sys_tb
  import mmu_pkg::*;
;

  localparam int PLEN      = 10;
  localparam int DEPTH     = (2 ** PLEN) / 4;
  localparam int RESET_CYC = 10;
  // Access counts per test
  localparam int N_FILL    = DEPTH;
  localparam int N_PAIR    = 16;
  localparam int N_LANE    = 4;
  localparam int N_FAULT   = 8;
  localparam int N_MIX     = 200;
  localparam int N_CMDS    = N_FILL + 2 * N_PAIR + 12 * N_LANE + 2 * N_FAULT + 5 + N_MIX;
  localparam int LIMIT     = N_CMDS * 8 + RESET_CYC + 100;

  logic            clk_i;
  logic            reset_i;
  logic            abort_i;
  logic            cmd_valid_i;
  host_cmd_t       cmd_i;
  logic            busy_o;
  logic            done_o;
  logic            fault_o;
  logic [XLEN-1:0] rdata_o;

  // Shadow of the data memory
  logic [XLEN-1:0] shadow [DEPTH];
  logic [15:0]     lfsr = 16'd31390;
  int              cyc = 0;
  int              mismatches = 0;
  int              other_errs = 0;

  // Pending accesses, oldest first
  string           name_q [$];
  logic            fault_exp_q [$];
  logic [XLEN-1:0] data_exp_q [$];
  int              lat_exp_q [$];
  int              start_q [$];

  mem_sys_top #(
    .PLEN (PLEN)
  ) dut_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .abort_i     (abort_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .fault_o     (fault_o),
    .rdata_o     (rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Forces one bit at or above PLEN
  function automatic logic [31:0] out_of_range(logic [31:0] adr);
    int pos;
    pos = PLEN + (rand_bits(5) % (XLEN - PLEN));
    return adr | (32'h1 << pos);
  endfunction

  // Distinct word for every index
  function automatic logic [31:0] fill_word(int idx);
    logic [7:0] b;
    b = idx[7:0];
    return {b, ~b, b ^ 8'h5a, 8'hc3 ^ {idx[9:8], 6'h0}};
  endfunction

  // Returns {fault, read word} and applies stores to the shadow
  function automatic logic [32:0] ref_access(op_e op, size_e sz, logic [31:0] adr,
                                             logic [31:0] data);
    logic [31:0] word;
    logic [7:0]  src;
    logic        hit;
    int          idx;
    if ((adr >> PLEN) != 0) return {1'b1, 32'h0};
    idx  = adr[PLEN-1:2];
    word = shadow[idx];
    if (op == OP_LOAD) return {1'b0, word};
    for (int b = 0; b < 4; b++) begin
      case (sz)
        SZ_BYTE: begin
          hit = (b == adr[1:0]);
          src = data[7:0];
        end
        SZ_HALF: begin
          hit = ((b >> 1) == adr[1]);
          src = data[8*(b%2) +: 8];
        end
        default: begin
          hit = 1'b1;
          src = data[8*b +: 8];
        end
      endcase
      if (hit) word[8*b +: 8] = src;
    end
    shadow[idx] = word;
    return {1'b0, 32'h0};
  endfunction

  ////////////////////////////////////////////////////////////
  // Host side driver
  ////////////////////////////////////////////////////////////

  // Entered and left on a falling edge
  task automatic issue(input string name, input op_e op, input size_e sz,
                       input logic [31:0] adr, input logic [31:0] data);
    logic [32:0] exp;
    while (busy_o) @(negedge clk_i);
    cmd_i.op    = op;
    cmd_i.size  = sz;
    cmd_i.adr   = adr;
    cmd_i.data  = data;
    cmd_valid_i = 1'b1;
    // Accept edge, cycle 0
    @(posedge clk_i);
    exp = ref_access(op, sz, adr, data);
    name_q.push_back(name);
    fault_exp_q.push_back(exp[32]);
    data_exp_q.push_back(exp[31:0]);
    lat_exp_q.push_back(exp[32] ? 3 : 5);
    start_q.push_back(cyc);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic print_counts();
    $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    string       nm;
    logic        f_exp;
    logic [31:0] d_exp;
    int          lat;
    int          lat_exp;
    if (!reset_i && done_o) begin
      assert (name_q.size() != 0) else begin
        other_errs++;
        $display("done_o seen at cycle %0d with no access pending", cyc);
      end
      if (name_q.size() != 0) begin
        nm      = name_q.pop_front();
        f_exp   = fault_exp_q.pop_front();
        d_exp   = data_exp_q.pop_front();
        lat_exp = lat_exp_q.pop_front();
        lat     = cyc - start_q.pop_front();
        assert (lat == lat_exp) else begin
          mismatches++;
          $display("Mismatch %s latency: expected %0d, actual %0d", nm, lat_exp, lat);
        end
        assert (fault_o === f_exp) else begin
          mismatches++;
          $display("Mismatch %s fault_o: expected %b, actual %b", nm, f_exp, fault_o);
        end
        assert (rdata_o === d_exp) else begin
          mismatches++;
          $display("Mismatch %s rdata_o: expected %h, actual %h", nm, d_exp, rdata_o);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      other_errs++;
      $display("Timeout after %0d cycles, %0d accesses outstanding", cyc, name_q.size());
      print_counts();
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [2:0]  sel;
    logic [1:0]  s2;
    op_e         op;
    size_e       sz;
    reset_i     = 1'b1;
    abort_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    repeat (RESET_CYC) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Known contents everywhere
    for (int i = 0; i < N_FILL; i++) begin
      issue("fill", OP_STORE, SZ_WORD, i * 4, fill_word(i));
    end

    // Word store then load
    for (int i = 0; i < N_PAIR; i++) begin
      a = rand_bits(PLEN - 2) << 2;
      d = rand_bits(32);
      issue("word_store", OP_STORE, SZ_WORD, a, d);
      issue("word_load", OP_LOAD, SZ_WORD, a, '0);
    end

    // Every byte lane and both halves
    for (int i = 0; i < N_LANE; i++) begin
      a = rand_bits(PLEN - 2) << 2;
      for (int l = 0; l < 4; l++) begin
        d = rand_bits(32);
        issue("byte_store", OP_STORE, SZ_BYTE, a + l, d);
        issue("byte_check", OP_LOAD, SZ_WORD, a, '0);
      end
      for (int h = 0; h < 2; h++) begin
        d = rand_bits(32);
        issue("half_store", OP_STORE, SZ_HALF, a + 2 * h, d);
        issue("half_check", OP_LOAD, SZ_WORD, a, '0);
      end
    end

    // Out of range stores leave the aliased word alone
    for (int i = 0; i < N_FAULT; i++) begin
      a = rand_bits(PLEN - 2) << 2;
      d = rand_bits(32);
      issue("fault_store", OP_STORE, SZ_WORD, out_of_range(a), d);
      issue("fault_alias", OP_LOAD, SZ_WORD, a, '0);
    end

    // Stray store while busy
    a = rand_bits(PLEN - 2) << 2;
    issue("busy_load", OP_LOAD, SZ_WORD, a, '0);
    assert (busy_o) else begin
      other_errs++;
      $display("busy_o low right after an accepted command");
    end
    cmd_i.op    = OP_STORE;
    cmd_i.size  = SZ_WORD;
    cmd_i.adr   = a;
    cmd_i.data  = ~shadow[a[PLEN-1:2]];
    cmd_valid_i = 1'b1;
    repeat (2) @(negedge clk_i);
    cmd_valid_i = 1'b0;
    issue("busy_check", OP_LOAD, SZ_WORD, a, '0);

    // Abort one cycle after an accepted store
    while (busy_o) @(negedge clk_i);
    cmd_i.op    = OP_STORE;
    cmd_i.size  = SZ_WORD;
    cmd_i.adr   = a;
    cmd_i.data  = ~shadow[a[PLEN-1:2]];
    cmd_valid_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    abort_i     = 1'b1;
    @(negedge clk_i);
    assert (!busy_o) else begin
      other_errs++;
      $display("busy_o still high in the cycle after abort");
    end
    abort_i = 1'b0;
    repeat (8) @(negedge clk_i);
    issue("abort_next", OP_LOAD, SZ_WORD, a, '0);

    // Random mix with some faults
    for (int i = 0; i < N_MIX; i++) begin
      sel = rand_bits(3);
      op  = rand_bits(1) ? OP_STORE : OP_LOAD;
      s2  = rand_bits(2);
      sz  = (s2 == 2'd0) ? SZ_BYTE : (s2 == 2'd1) ? SZ_HALF : SZ_WORD;
      a   = rand_bits(PLEN);
      d   = rand_bits(32);
      if (sel == 3'd0) a = out_of_range(a);
      issue("mix", op, sz, a, d);
    end

    // Drain the last access
    for (int k = 0; k < 20 && name_q.size() != 0; k++) begin
      @(negedge clk_i);
    end
    assert (name_q.size() == 0) else begin
      other_errs++;
      $display("done_o missing for %0d accesses", name_q.size());
    end

    print_counts();
    if (mismatches == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: common/mmu_pkg.sv
package mmu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data and virtual address width
  localparam int XLEN = 32;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Access direction
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  // Access size, same 3-bit code as the core bus side
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } size_e;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ISSUE = 2'd1,
    ST_WAIT  = 2'd2
  } lsu_state_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Request on either side of the MMU
  typedef struct packed {
    logic [XLEN-1:0] adr;
    size_e           size;
    logic            lock;
    logic [2:0]      prot;
    logic            we;
    logic [XLEN-1:0] data;
  } mem_req_t;

  // Command from the host
  typedef struct packed {
    op_e             op;
    size_e           size;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] data;
  } host_cmd_t;

endpackage

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem
  import mmu_pkg::*;
#(
  parameter int PLEN = 10
) (
  input  logic            clk_i,
  input  logic            reset_i,
  // Physical request
  input  logic            preq_i,
  input  mem_req_t        preq_data_i,
  // Acknowledge and read word
  output logic            pack_o,
  output logic [XLEN-1:0] pq_o
);

  // Word count from the physical range
  localparam int DEPTH = (2 ** PLEN) / 4;

  logic [XLEN-1:0] mem_q [DEPTH];
  logic [PLEN-3:0] word_idx;
  logic [3:0]      lane_we;
  logic [XLEN-1:0] wdata;
  logic [1:0]      ack_q;
  logic [XLEN-1:0] rd_q;
  logic [XLEN-1:0] pq_q;

  assign word_idx = preq_data_i.adr[PLEN-1:2];

  ////////////////////////////////////////////////////////////
  // Byte lane selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    lane_we = 4'b1111;
    wdata   = preq_data_i.data;
    case (preq_data_i.size)
      SZ_BYTE: begin
        // One lane picked by adr[1:0]
        lane_we = 4'b0001 << preq_data_i.adr[1:0];
        wdata   = {4{preq_data_i.data[7:0]}};
      end
      SZ_HALF: begin
        // Upper or lower half by adr[1]
        lane_we = preq_data_i.adr[1] ? 4'b1100 : 4'b0011;
        wdata   = {2{preq_data_i.data[15:0]}};
      end
      default: begin
        lane_we = 4'b1111;
      end
    endcase
  end

  // Store lands in the cycle preq is sampled
  always_ff @(posedge clk_i) begin
    if (preq_i && preq_data_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_we[i]) begin
          mem_q[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Two-deep response delay
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 2'b00;
    end else begin
      ack_q <= {ack_q[0], preq_i};
    end
  end

  // Read word follows the acknowledge
  always_ff @(posedge clk_i) begin
    if (preq_i) begin
      rd_q <= mem_q[word_idx];
    end
    pq_q <= rd_q;
  end

  assign pack_o = ack_q[1];
  assign pq_o   = pq_q;

endmodule

// File: hw/lsu_seq.sv
`timescale 1ns/1ps

module lsu_seq
  import mmu_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            abort_i,
  // Host command
  input  logic            cmd_valid_i,
  input  host_cmd_t       cmd_i,
  // Virtual request to the MMU
  output logic            vreq_o,
  output mem_req_t        vreq_data_o,
  // Responses from MMU and memory
  input  logic            page_fault_i,
  input  logic            pack_i,
  input  logic [XLEN-1:0] pq_i,
  // Status back to the host
  output logic            busy_o,
  output logic            done_o,
  output logic            fault_o,
  output logic [XLEN-1:0] rdata_o
);

  // Attributes used for every data access
  localparam logic       LOCK_NONE = 1'b0;
  localparam logic [2:0] PROT_DATA = 3'b001;

  lsu_state_e      state_q;
  host_cmd_t       cmd_q;
  logic            done_q;
  logic            fault_q;
  logic [XLEN-1:0] rdata_q;
  logic            accept;

  // Take a command only when fully idle
  assign accept = cmd_valid_i && !busy_o && !abort_i;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      fault_q <= 1'b0;
      rdata_q <= '0;
    end else if (abort_i) begin
      // Drop the access silently
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      // Done and fault are single pulses
      done_q  <= 1'b0;
      fault_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          state_q <= ST_WAIT;
        end
        ST_WAIT: begin
          if (page_fault_i) begin
            // Refused by the MMU
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
            fault_q <= 1'b1;
            rdata_q <= '0;
          end else if (pack_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
            // Only loads return data
            rdata_q <= (cmd_q.op == OP_LOAD) ? pq_i : '0;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Command payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request build and status
  ////////////////////////////////////////////////////////////

  always_comb begin
    vreq_data_o.adr  = cmd_q.adr;
    vreq_data_o.size = cmd_q.size;
    vreq_data_o.lock = LOCK_NONE;
    vreq_data_o.prot = PROT_DATA;
    vreq_data_o.we   = (cmd_q.op == OP_STORE);
    vreq_data_o.data = cmd_q.data;
  end

  // Request pulse for the single issue cycle
  assign vreq_o = (state_q == ST_ISSUE);

  // Busy also covers the done cycle
  assign busy_o  = (state_q != ST_IDLE) || done_q;
  assign done_o  = done_q;
  assign fault_o = fault_q;
  assign rdata_o = rdata_q;

endmodule

// File: hw/mem_sys_top.sv
`timescale 1ns/1ps

module mem_sys_top
  import mmu_pkg::*;
#(
  parameter int PLEN = 10
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            abort_i,
  // Host command
  input  logic            cmd_valid_i,
  input  host_cmd_t       cmd_i,
  // Host status
  output logic            busy_o,
  output logic            done_o,
  output logic            fault_o,
  output logic [XLEN-1:0] rdata_o
);

  // Sequencer to MMU
  logic            vreq;
  mem_req_t        vreq_data;
  // MMU to memory
  logic            preq;
  mem_req_t        preq_data;
  logic            page_fault;
  // Memory back to sequencer
  logic            pack;
  logic [XLEN-1:0] pq;

  ////////////////////////////////////////////////////////////
  // Load/store sequencer
  ////////////////////////////////////////////////////////////

  lsu_seq lsu_seq_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .abort_i      (abort_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .vreq_o       (vreq),
    .vreq_data_o  (vreq_data),
    .page_fault_i (page_fault),
    .pack_i       (pack),
    .pq_i         (pq),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .fault_o      (fault_o),
    .rdata_o      (rdata_o)
  );

  // Abort also clears the MMU stage
  mmu_stage #(
    .PLEN (PLEN)
  ) mmu_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .clr_i        (abort_i),
    .vreq_i       (vreq),
    .vreq_data_i  (vreq_data),
    .preq_o       (preq),
    .preq_data_o  (preq_data),
    .page_fault_o (page_fault)
  );

  data_mem #(
    .PLEN (PLEN)
  ) data_mem_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .preq_i      (preq),
    .preq_data_i (preq_data),
    .pack_o      (pack),
    .pq_o        (pq)
  );

endmodule

// File: list.f
common/mmu_pkg.sv
hw/lsu_seq.sv
mmu/mmu_stage.sv
hw/data_mem.sv
hw/mem_sys_top.sv
bench/mem_sys_tb.sv

// File: mmu/mmu_stage.sv
`timescale 1ns/1ps

module mmu_stage
  import mmu_pkg::*;
#(
  parameter int PLEN = 10
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Cancels whatever is pending
  input  logic     clr_i,
  // Virtual side
  input  logic     vreq_i,
  input  mem_req_t vreq_data_i,
  // Physical side
  output logic     preq_o,
  output mem_req_t preq_data_o,
  // Out of range access
  output logic     page_fault_o
);

  logic     in_range;
  logic     preq_q;
  logic     fault_q;
  mem_req_t preq_data_q;

  ////////////////////////////////////////////////////////////
  // Physical range check
  ////////////////////////////////////////////////////////////

  // All bits from PLEN upward must be clear
  assign in_range = ((vreq_data_i.adr >> PLEN) == '0);

  ////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////

  // Request or fault, never both
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      preq_q  <= 1'b0;
      fault_q <= 1'b0;
    end else if (clr_i) begin
      preq_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      preq_q  <= vreq_i && in_range;
      fault_q <= vreq_i && !in_range;
    end
  end

  // Bare mode
  // Physical address is the virtual one, other fields pass as is
  always_ff @(posedge clk_i) begin
    if (vreq_i) begin
      preq_data_q <= vreq_data_i;
    end
  end

  assign preq_o       = preq_q;
  assign preq_data_o  = preq_data_q;
  assign page_fault_o = fault_q;

endmodule
